//--- Bender.yml
package:
  name: flash_load

sources:
  - flash_load_pkg.sv
  - load_ifs.sv
  - load_cfg_regs.sv
  - load_flash_fsm.sv
  - seg_copy_engine.sv
  - flash_load_top.sv
  - target: test
    files:
      - flash_load_assertions.sv
      - tb_flash_load.sv

//--- flash_load_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module flash_load_assertions (
	input logic                              sys_clk,
	input logic                              glbl_rst_n,
	input logic                              flash_rd_req,
	input logic [flash_load_pkg::ADDR_W-1:0] flash_rd_addr,
	input logic                              flash_rd_valid,
	input logic                              flash_fsm_done,
	input logic                              flash_fsm_error,
	input logic                              ram_wr_en
);

	int fail_count = 0;

	// Request and address held until valid unless the run aborts
	req_held: assert property (@(posedge sys_clk) disable iff (!glbl_rst_n)
		flash_rd_req && !flash_rd_valid && !flash_fsm_error
		|=> flash_rd_req && $stable(flash_rd_addr))
	else
	begin
		fail_count++;
		$error("flash read request dropped or moved before valid");
	end

	end_excl: assert property (@(posedge sys_clk) disable iff (!glbl_rst_n)
		!(flash_fsm_done && flash_fsm_error))
	else
	begin
		fail_count++;
		$error("done and error raised together");
	end

	// A RAM write always carries the word of the previous valid
	wr_after_valid: assert property (@(posedge sys_clk) disable iff (!glbl_rst_n)
		ram_wr_en |-> $past(flash_rd_valid))
	else
	begin
		fail_count++;
		$error("RAM write without a preceding flash valid");
	end

endmodule

bind flash_load_top flash_load_assertions asrt0 (
	.sys_clk         (sys_clk),
	.glbl_rst_n      (glbl_rst_n),
	.flash_rd_req    (flash_rd_req),
	.flash_rd_addr   (flash_rd_addr),
	.flash_rd_valid  (flash_rd_valid),
	.flash_fsm_done  (flash_fsm_done),
	.flash_fsm_error (flash_fsm_error),
	.ram_wr_en       (ram_wr_en)
);

`default_nettype wire

//--- flash_load_pkg.sv
`default_nettype none

package flash_load_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////

	// Flash and RAM word address width
	localparam int ADDR_W = 16;
	// Data word width, also the checksum width
	localparam int DATA_W = 16;
	// Stage number in bits 2:1, field select in bit 0
	localparam int CFG_ADDR_W = 3;

	//////////////////////////////
	// Stages in run order
	//////////////////////////////

	typedef enum logic [1:0]
	{
		stage_xfer  = 2'd0,
		stage_card  = 2'd1,
		stage_afpga = 2'd2,
		stage_cons  = 2'd3
	} load_stage_e;

	//////////////////////////////
	// Configuration write word
	//////////////////////////////

	// Field select 0
	typedef struct packed
	{
		logic [ADDR_W-1:0] flash_base;
		logic [ADDR_W-1:0] ram_base;
	} cfg_addr_t;

	// Field select 1
	typedef struct packed
	{
		logic [ADDR_W-1:0] word_count;
		logic [DATA_W-1:0] checksum;
	} cfg_size_t;

	typedef union packed
	{
		cfg_addr_t addr;
		cfg_size_t size;
	} cfg_word_u;

	// One stage descriptor, 64 bits
	typedef struct packed
	{
		logic [ADDR_W-1:0] flash_base;
		logic [ADDR_W-1:0] ram_base;
		logic [ADDR_W-1:0] word_count;
		logic [DATA_W-1:0] checksum;
	} load_desc_t;

endpackage

`default_nettype wire

//--- flash_load_top.sv
`timescale 1ns/10ps
`default_nettype none

module flash_load_top (
	input  logic                                   sys_clk,
	input  logic                                   glbl_rst_n,
	// Sequencer
	input  logic                                   fram_fsm_done,
	input  logic                                   fram_fsm_error,
	output logic                                   flash_fsm_done,
	output logic                                   flash_fsm_error,
	output flash_load_pkg::load_stage_e            error_stage,
	// Configuration
	input  logic                                   cfg_wr_en,
	input  logic [flash_load_pkg::CFG_ADDR_W-1:0]  cfg_wr_addr,
	input  flash_load_pkg::cfg_word_u              cfg_wr_data,
	// Flash read port
	output logic                                   flash_rd_req,
	output logic [flash_load_pkg::ADDR_W-1:0]      flash_rd_addr,
	input  logic                                   flash_rd_valid,
	input  logic [flash_load_pkg::DATA_W-1:0]      flash_rd_data,
	input  logic                                   flash_rd_err,
	// RAM write port
	output logic                                   ram_wr_en,
	output logic [flash_load_pkg::ADDR_W-1:0]      ram_wr_addr,
	output logic [flash_load_pkg::DATA_W-1:0]      ram_wr_data
);

	desc_if     desc_bus ();
	copy_ctl_if ctl_bus ();

	load_cfg_regs cfg_regs0 (
		.sys_clk     (sys_clk),
		.glbl_rst_n  (glbl_rst_n),
		.cfg_wr_en   (cfg_wr_en),
		.cfg_wr_addr (cfg_wr_addr),
		.cfg_wr_data (cfg_wr_data),
		.desc        (desc_bus.regs)
	);

	load_flash_fsm seq0 (
		.sys_clk         (sys_clk),
		.glbl_rst_n      (glbl_rst_n),
		.fram_fsm_done   (fram_fsm_done),
		.fram_fsm_error  (fram_fsm_error),
		.flash_fsm_done  (flash_fsm_done),
		.flash_fsm_error (flash_fsm_error),
		.error_stage     (error_stage),
		.ctl             (ctl_bus.seq)
	);

	seg_copy_engine engine0 (
		.sys_clk        (sys_clk),
		.glbl_rst_n     (glbl_rst_n),
		.ctl            (ctl_bus.engine),
		.desc           (desc_bus.engine),
		.flash_rd_req   (flash_rd_req),
		.flash_rd_addr  (flash_rd_addr),
		.flash_rd_valid (flash_rd_valid),
		.flash_rd_err   (flash_rd_err),
		.flash_rd_data  (flash_rd_data),
		.ram_wr_en      (ram_wr_en),
		.ram_wr_addr    (ram_wr_addr),
		.ram_wr_data    (ram_wr_data)
	);

endmodule

`default_nettype wire

//--- flist.f
flash_load_pkg.sv
load_ifs.sv
load_cfg_regs.sv
load_flash_fsm.sv
seg_copy_engine.sv
flash_load_top.sv
flash_load_assertions.sv
tb_flash_load.sv

//--- load_cfg_regs.sv
`timescale 1ns/10ps
`default_nettype none

module load_cfg_regs (
	input  logic                                    sys_clk,
	input  logic                                    glbl_rst_n,
	input  logic                                    cfg_wr_en,
	input  logic [flash_load_pkg::CFG_ADDR_W-1:0]  cfg_wr_addr,
	input  flash_load_pkg::cfg_word_u               cfg_wr_data,
	desc_if.regs                                    desc
);

	// One descriptor per stage
	flash_load_pkg::load_desc_t desc_mem [4];

	logic [1:0] wr_stage;
	logic       wr_size;

	// Address decode
	assign wr_stage = cfg_wr_addr[2:1];
	assign wr_size  = cfg_wr_addr[0];

	//////////////////////////////
	// Write side
	//////////////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			for (int i = 0; i < 4; i++)
			begin
				desc_mem[i] <= '0;
			end
		end
		else if (cfg_wr_en)
		begin
			if (wr_size)
			begin
				// Size half of the descriptor
				desc_mem[wr_stage].word_count <= cfg_wr_data.size.word_count;
				desc_mem[wr_stage].checksum   <= cfg_wr_data.size.checksum;
			end
			else
			begin
				// Address half of the descriptor
				desc_mem[wr_stage].flash_base <= cfg_wr_data.addr.flash_base;
				desc_mem[wr_stage].ram_base   <= cfg_wr_data.addr.ram_base;
			end
		end
	end

	//////////////////////////////
	// Read side
	//////////////////////////////

	// Engine picks the stage, no latency
	assign desc.desc = desc_mem[desc.stage_sel];

endmodule

`default_nettype wire

//--- load_flash_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module load_flash_fsm (
	input  logic                        sys_clk,
	input  logic                        glbl_rst_n,
	input  logic                        fram_fsm_done,
	input  logic                        fram_fsm_error,
	output logic                        flash_fsm_done,
	output logic                        flash_fsm_error,
	output flash_load_pkg::load_stage_e error_stage,
	copy_ctl_if.seq                     ctl
);

	// Stage states follow run order
	localparam logic [2:0] st_idle  = 3'd0;
	localparam logic [2:0] st_xfer  = 3'd1;
	localparam logic [2:0] st_card  = 3'd2;
	localparam logic [2:0] st_afpga = 3'd3;
	localparam logic [2:0] st_cons  = 3'd4;

	logic [2:0] state;

	//////////////////////////////
	// Sequencer
	//////////////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			state           <= st_idle;
			flash_fsm_done  <= 1'b0;
			flash_fsm_error <= 1'b0;
			error_stage     <= flash_load_pkg::stage_xfer;
			ctl.copy_start  <= 1'b0;
			ctl.copy_abort  <= 1'b0;
			ctl.copy_stage  <= flash_load_pkg::stage_xfer;
		end
		else
		begin
			// All outputs are single-cycle pulses
			flash_fsm_done  <= 1'b0;
			flash_fsm_error <= 1'b0;
			ctl.copy_start  <= 1'b0;
			ctl.copy_abort  <= 1'b0;

			if (state == st_idle)
			begin
				// FRAM step finished, start with xfer
				if (fram_fsm_done)
				begin
					state          <= st_xfer;
					ctl.copy_start <= 1'b1;
					ctl.copy_stage <= flash_load_pkg::stage_xfer;
				end
			end
			else if (fram_fsm_error)
			begin
				// FRAM trouble overrides whatever the engine reports
				state           <= st_idle;
				ctl.copy_abort  <= 1'b1;
				flash_fsm_error <= 1'b1;
				error_stage     <= ctl.copy_stage;
			end
			else if (ctl.copy_fail)
			begin
				state           <= st_idle;
				flash_fsm_error <= 1'b1;
				error_stage     <= ctl.copy_stage;
			end
			else if (ctl.copy_done)
			begin
				if (state == st_cons)
				begin
					// Last image copied
					state          <= st_idle;
					flash_fsm_done <= 1'b1;
				end
				else
				begin
					// xfer -> card -> afpga -> cons
					state          <= state + 3'd1;
					ctl.copy_start <= 1'b1;
					ctl.copy_stage <= flash_load_pkg::load_stage_e'(ctl.copy_stage + 2'd1);
				end
			end
			else if (state > st_cons)
			begin
				state <= st_idle;
			end
		end
	end

endmodule

`default_nettype wire

//--- load_ifs.sv
`timescale 1ns/10ps
`default_nettype none

//////////////////////////////
// Descriptor lookup
//////////////////////////////

interface desc_if;
	flash_load_pkg::load_stage_e stage_sel;
	// Answered combinationally by the register block
	flash_load_pkg::load_desc_t  desc;

	modport engine (output stage_sel, input desc);
	modport regs (input stage_sel, output desc);
endinterface

//////////////////////////////
// Copy control
//////////////////////////////

interface copy_ctl_if;
	// Single-cycle pulses from the sequencer
	logic                        copy_start;
	logic                        copy_abort;
	flash_load_pkg::load_stage_e copy_stage;
	// Single-cycle pulses back, never both together
	logic                        copy_done;
	logic                        copy_fail;

	modport seq (
		output copy_start, copy_stage, copy_abort,
		input  copy_done, copy_fail
	);
	modport engine (
		input  copy_start, copy_stage, copy_abort,
		output copy_done, copy_fail
	);
endinterface

`default_nettype wire

//--- seg_copy_engine.sv
`timescale 1ns/10ps
`default_nettype none

module seg_copy_engine (
	input  logic                               sys_clk,
	input  logic                               glbl_rst_n,
	copy_ctl_if.engine                         ctl,
	desc_if.engine                             desc,
	output logic                               flash_rd_req,
	output logic [flash_load_pkg::ADDR_W-1:0]  flash_rd_addr,
	input  logic                               flash_rd_valid,
	input  logic                               flash_rd_err,
	input  logic [flash_load_pkg::DATA_W-1:0]  flash_rd_data,
	output logic                               ram_wr_en,
	output logic [flash_load_pkg::ADDR_W-1:0]  ram_wr_addr,
	output logic [flash_load_pkg::DATA_W-1:0]  ram_wr_data
);

	localparam logic [1:0] eng_idle  = 2'd0;
	localparam logic [1:0] eng_read  = 2'd1;
	localparam logic [1:0] eng_write = 2'd2;

	logic [1:0]                        state;
	flash_load_pkg::load_desc_t        desc_q;
	logic [flash_load_pkg::ADDR_W-1:0] word_idx;
	logic [flash_load_pkg::ADDR_W-1:0] word_idx_next;
	logic [flash_load_pkg::DATA_W-1:0] data_q;
	logic [flash_load_pkg::DATA_W-1:0] sum;
	logic [flash_load_pkg::DATA_W-1:0] sum_next;

	assign desc.stage_sel = ctl.copy_stage;

	// Running sum wraps at 16 bits
	assign sum_next      = sum + data_q;
	assign word_idx_next = word_idx + 1'b1;

	//////////////////////////////
	// Port side
	//////////////////////////////

	// One read in flight, address held until valid
	assign flash_rd_req  = (state == eng_read);
	assign flash_rd_addr = desc_q.flash_base + word_idx;

	assign ram_wr_en   = (state == eng_write);
	assign ram_wr_addr = desc_q.ram_base + word_idx;
	assign ram_wr_data = data_q;

	//////////////////////////////
	// Control
	//////////////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			state         <= eng_idle;
			word_idx      <= '0;
			sum           <= '0;
			ctl.copy_done <= 1'b0;
			ctl.copy_fail <= 1'b0;
		end
		else
		begin
			ctl.copy_done <= 1'b0;
			ctl.copy_fail <= 1'b0;

			if (ctl.copy_abort)
			begin
				// Quiet return, no status pulse
				state <= eng_idle;
			end
			else
			begin
				case (state)
					eng_idle:
					begin
						if (ctl.copy_start)
						begin
							word_idx <= '0;
							sum      <= '0;
							if (desc.desc.word_count == '0)
							begin
								// Empty image, only the checksum matters
								ctl.copy_done <= (desc.desc.checksum == '0);
								ctl.copy_fail <= (desc.desc.checksum != '0);
							end
							else
							begin
								state <= eng_read;
							end
						end
					end
					eng_read:
					begin
						if (flash_rd_valid)
						begin
							if (flash_rd_err)
							begin
								// Bad word is dropped
								ctl.copy_fail <= 1'b1;
								state         <= eng_idle;
							end
							else
							begin
								state <= eng_write;
							end
						end
					end
					eng_write:
					begin
						sum      <= sum_next;
						word_idx <= word_idx_next;
						if (word_idx_next == desc_q.word_count)
						begin
							ctl.copy_done <= (sum_next == desc_q.checksum);
							ctl.copy_fail <= (sum_next != desc_q.checksum);
							state         <= eng_idle;
						end
						else
						begin
							state <= eng_read;
						end
					end
					default:
					begin
						state <= eng_idle;
					end
				endcase
			end
		end
	end

	// Payload registers
	always_ff @(posedge sys_clk)
	begin
		if (state == eng_idle && ctl.copy_start)
		begin
			desc_q <= desc.desc;
		end
		if (state == eng_read && flash_rd_valid)
		begin
			data_q <= flash_rd_data;
		end
	end

endmodule

`default_nettype wire

//--- tb_flash_load.sv
`timescale 1ns/10ps
`default_nettype none

module tb_flash_load;

	localparam int num_runs = 5;
	// 5 runs x 64 words x 8 cycles, plus margin for config writes and gaps
	localparam int timeout_cycles = 20000;
	localparam int mode_full  = 0;
	localparam int mode_csum  = 1;
	localparam int mode_rderr = 2;
	localparam int mode_fram  = 3;

	logic                                  sys_clk;
	logic                                  glbl_rst_n;
	logic                                  fram_fsm_done;
	logic                                  fram_fsm_error;
	logic                                  flash_fsm_done;
	logic                                  flash_fsm_error;
	flash_load_pkg::load_stage_e           error_stage;
	logic                                  cfg_wr_en;
	logic [flash_load_pkg::CFG_ADDR_W-1:0] cfg_wr_addr;
	flash_load_pkg::cfg_word_u             cfg_wr_data;
	logic                                  flash_rd_req;
	logic [flash_load_pkg::ADDR_W-1:0]     flash_rd_addr;
	logic                                  flash_rd_valid;
	logic [flash_load_pkg::DATA_W-1:0]     flash_rd_data;
	logic                                  flash_rd_err;
	logic                                  ram_wr_en;
	logic [flash_load_pkg::ADDR_W-1:0]     ram_wr_addr;
	logic [flash_load_pkg::DATA_W-1:0]     ram_wr_data;

	// Stimulus and reference model state
	logic [15:0]                 lfsr_state;
	logic [15:0]                 flash_mem [128];
	logic [15:0]                 exp_rd_q [$];
	logic [15:0]                 exp_wa_q [$];
	logic [15:0]                 exp_wd_q [$];
	flash_load_pkg::load_desc_t  run_desc [4];
	flash_load_pkg::load_stage_e fail_stage;
	logic [15:0]                 err_addr;
	logic [15:0]                 fram_addr;
	logic                        err_en;
	logic                        fram_en;
	logic                        freeze;
	logic                        rd_busy;
	int                          rd_wait;
	int                          rd_lat;
	int                          fail_idx;
	int                          cycle_cnt = 0;
	int                          done_pulses = 0;
	int                          error_pulses = 0;
	int                          run_modes [num_runs] = '{mode_full, mode_csum, mode_rderr,
		mode_fram, mode_full};

	flash_load_top dut0 (.*);

	initial
	begin
		sys_clk = 1'b0;
	end

	always #20 sys_clk = ~sys_clk;

	//////////////////////////////
	// Random source and checks
	//////////////////////////////

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic int unsigned rand_bits(input int n);
		int unsigned v;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			v = (v << 1) | lfsr_step();
		end
		return v;
	endfunction

	task automatic halt_sim();
		$display("TB FAILED");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic report_mismatch(input string msg);
		$display("[ERROR] time %0t: %s", $time, msg);
		halt_sim();
	endtask

	task automatic compare_word(input logic [flash_load_pkg::DATA_W-1:0] got,
		input logic [flash_load_pkg::DATA_W-1:0] exp, input string what);
		if (got !== exp)
		begin
			report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
		end
	endtask

	task automatic compare_stage(input flash_load_pkg::load_stage_e got,
		input flash_load_pkg::load_stage_e exp);
		if (got !== exp)
		begin
			report_mismatch($sformatf("error_stage is %0d, expected %0d", got, exp));
		end
	endtask

	task automatic compare_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
		end
	endtask

	task automatic write_cfg(input logic [2:0] addr, input flash_load_pkg::cfg_word_u data);
		@(negedge sys_clk);
		cfg_wr_en   = 1'b1;
		cfg_wr_addr = addr;
		cfg_wr_data = data;
		@(negedge sys_clk);
		cfg_wr_en = 1'b0;
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	task automatic setup_run(input int mode, input logic empty_card);
		flash_load_pkg::cfg_word_u w;
		logic [15:0] sum;
		logic [15:0] a;
		logic stop;
		for (int i = 0; i < 128; i++)
		begin
			flash_mem[i] = 16'(rand_bits(16));
		end
		for (int s = 0; s < 4; s++)
		begin
			// Regions 32 words apart never overlap
			run_desc[s].flash_base = 16'(16'h4000 + s * 32 + rand_bits(4));
			run_desc[s].ram_base   = 16'(16'h8000 + s * 32 + rand_bits(4));
			if (mode == mode_full)
				run_desc[s].word_count = 16'(rand_bits(5) % 17);
			else
				run_desc[s].word_count = 16'(1 + rand_bits(4));
			if (empty_card && s == 1)
				run_desc[s].word_count = '0;
			sum = '0;
			for (int i = 0; i < int'(run_desc[s].word_count); i++)
			begin
				sum = sum + flash_mem[7'(run_desc[s].flash_base + i)];
			end
			run_desc[s].checksum = sum;
		end
		fail_stage = flash_load_pkg::load_stage_e'(2'(rand_bits(2)));
		fail_idx   = int'(rand_bits(4) % run_desc[fail_stage].word_count);
		if (mode == mode_csum)
			run_desc[fail_stage].checksum += 16'(1 + rand_bits(8));
		err_en    = (mode == mode_rderr);
		fram_en   = (mode == mode_fram);
		err_addr  = run_desc[fail_stage].flash_base + 16'(fail_idx);
		fram_addr = err_addr;
		freeze    = 1'b0;

		// Expected reads and writes in stage order
		exp_rd_q.delete();
		exp_wa_q.delete();
		exp_wd_q.delete();
		stop = 1'b0;
		for (int s = 0; s < 4 && !stop; s++)
		begin
			for (int i = 0; i < int'(run_desc[s].word_count) && !stop; i++)
			begin
				a = run_desc[s].flash_base + 16'(i);
				exp_rd_q.push_back(a);
				if ((err_en || fram_en) && s == int'(fail_stage) && i == fail_idx)
				begin
					stop = 1'b1;
				end
				else
				begin
					exp_wa_q.push_back(run_desc[s].ram_base + 16'(i));
					exp_wd_q.push_back(flash_mem[a[6:0]]);
				end
			end
			if (mode != mode_full && s == int'(fail_stage))
				stop = 1'b1;
		end

		for (int s = 0; s < 4; s++)
		begin
			w.addr.flash_base = run_desc[s].flash_base;
			w.addr.ram_base   = run_desc[s].ram_base;
			write_cfg(3'(2 * s), w);
			w.size.word_count = run_desc[s].word_count;
			w.size.checksum   = run_desc[s].checksum;
			write_cfg(3'(2 * s + 1), w);
		end
	endtask

	//////////////////////////////
	// Flash model and monitors
	//////////////////////////////

	always @(negedge sys_clk)
	begin
		flash_rd_valid = 1'b0;
		flash_rd_err   = 1'b0;
		fram_fsm_error = 1'b0;
		if (flash_rd_req !== 1'b1)
		begin
			rd_busy = 1'b0;
		end
		else if (!freeze)
		begin
			if (!rd_busy)
			begin
				if (exp_rd_q.size() == 0)
				begin
					$display("Flash read at %h was not expected in this run", flash_rd_addr);
					halt_sim();
				end
				else
				begin
					compare_word(flash_rd_addr, exp_rd_q.pop_front(), "flash_rd_addr");
				end
				rd_busy = 1'b1;
				rd_wait = 0;
				rd_lat  = 1 + int'(rand_bits(2));
				if (fram_en && flash_rd_addr == fram_addr)
				begin
					// Read stays open while the FRAM error aborts the run
					fram_fsm_error = 1'b1;
					freeze         = 1'b1;
				end
			end
			if (!freeze)
			begin
				rd_wait++;
				if (rd_wait == rd_lat)
				begin
					flash_rd_valid = 1'b1;
					flash_rd_data  = flash_mem[flash_rd_addr[6:0]];
					flash_rd_err   = err_en && (flash_rd_addr == err_addr);
					rd_busy        = 1'b0;
				end
			end
		end
	end

	always @(negedge sys_clk)
	begin
		if (dut0.asrt0.fail_count != 0)
		begin
			$display("A concurrent assertion on the DUT ports failed");
			halt_sim();
		end
		if (glbl_rst_n)
		begin
			if (ram_wr_en)
			begin
				if (exp_wa_q.size() == 0)
				begin
					$display("RAM write to %h came after the expected writes ended", ram_wr_addr);
					halt_sim();
				end
				else
				begin
					compare_word(ram_wr_addr, exp_wa_q.pop_front(), "ram_wr_addr");
					compare_word(ram_wr_data, exp_wd_q.pop_front(), "ram_wr_data");
				end
			end
			if (flash_fsm_done)
				done_pulses++;
			if (flash_fsm_error)
				error_pulses++;
			if (done_pulses > 1 || error_pulses > 1)
			begin
				$display("More than one done or error pulse in a single run");
				halt_sim();
			end
		end
	end

	always @(posedge sys_clk)
	begin
		cycle_cnt++;
		if (cycle_cnt >= timeout_cycles)
		begin
			$display("Timeout, the run hung for %0d cycles without finishing", cycle_cnt);
			halt_sim();
		end
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial
	begin
		lfsr_state     = 16'd4162;
		glbl_rst_n     = 1'b0;
		fram_fsm_done  = 1'b0;
		fram_fsm_error = 1'b0;
		cfg_wr_en      = 1'b0;
		cfg_wr_addr    = '0;
		cfg_wr_data    = '0;
		flash_rd_valid = 1'b0;
		flash_rd_data  = '0;
		flash_rd_err   = 1'b0;
		err_en         = 1'b0;
		fram_en        = 1'b0;
		freeze         = 1'b0;
		rd_busy        = 1'b0;
		repeat (8) @(negedge sys_clk);
		glbl_rst_n = 1'b1;
		@(negedge sys_clk);
		compare_flag(flash_fsm_done, 1'b0, "flash_fsm_done after reset");
		compare_flag(flash_fsm_error, 1'b0, "flash_fsm_error after reset");
		compare_flag(flash_rd_req, 1'b0, "flash_rd_req after reset");
		compare_flag(ram_wr_en, 1'b0, "ram_wr_en after reset");

		for (int r = 0; r < num_runs; r++)
		begin
			setup_run(run_modes[r], r == 0);
			done_pulses  = 0;
			error_pulses = 0;
			@(negedge sys_clk);
			fram_fsm_done = 1'b1;
			@(negedge sys_clk);
			fram_fsm_done = 1'b0;
			// Second pulse lands while busy and must be ignored
			@(negedge sys_clk);
			fram_fsm_done = 1'b1;
			@(negedge sys_clk);
			fram_fsm_done = 1'b0;
			while (done_pulses == 0 && error_pulses == 0)
				@(negedge sys_clk);
			// Quiet window catches late writes or a restart
			repeat (10) @(negedge sys_clk);
			compare_flag(done_pulses != 0, run_modes[r] == mode_full, "flash_fsm_done seen");
			compare_flag(error_pulses != 0, run_modes[r] != mode_full, "flash_fsm_error seen");
			if (run_modes[r] != mode_full)
				compare_stage(error_stage, fail_stage);
			if (exp_wa_q.size() != 0 || exp_rd_q.size() != 0)
			begin
				$display("Run %0d ended with expected flash reads or RAM writes missing", r);
				halt_sim();
			end
		end

		if (dut0.asrt0.fail_count != 0)
		begin
			$display("Concurrent assertions failed %0d times", dut0.asrt0.fail_count);
			halt_sim();
		end
		else
		begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire
